/* sources.f */
logic/rta_cfg_pkg.sv
logic/rta_geom_pkg.sv
logic/apb_regs.sv
logic/command_processor.sv
logic/mem_triangle.sv
logic/ic_core.sv
logic/mem_result.sv
logic/rta_top.sv
dv/rta_chk.sv
dv/rta_tb.sv

/* dv/rta_tb.sv */
// Accelerator directed testbench
`default_nettype none

module rta_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;

  // Core time per pixel is 4 cycles per triangle plus handshake and margin
  localparam int RUN_CYCLES = 16 * (4 * 1 + 8) + 256 * (4 * 3 + 8) + 2 * 64 * 8 +
                              256 * (4 * 3 + 8) + 16 * (4 * 1 + 8);
  // About 420 APB transfers of at most 5 cycles each
  localparam int APB_CYCLES = 5 * 420;
  localparam int MAX_CYCLES = 2 * (RUN_CYCLES + APB_CYCLES);

  logic                           clk;
  logic                           rst;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  logic [rta_cfg_pkg::ADDR_W-1:0] paddr;
  logic [31:0]                    pwdata;
  logic [31:0]                    prdata;
  logic                           pready;
  logic                           pslverr;
  logic                           irq;

  int seed;
  int cycle_count = 0;

  // Reference model of the loaded triangles
  int model_count;
  int tri_x [rta_cfg_pkg::NUM_TRI][3];
  int tri_y [rta_cfg_pkg::NUM_TRI][3];
  int tri_depth [rta_cfg_pkg::NUM_TRI];
  int tri_sid [rta_cfg_pkg::NUM_TRI];

  rta_top rta_top_inst (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .irq(irq)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
      stop_fail("timeout, the DUT did not finish in time");
  end

  task automatic stop_fail(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stop_fail($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  // ==========================================================================
  // APB transfers
  // ==========================================================================
  task automatic apb_xfer(input logic write, input logic [rta_cfg_pkg::ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err, output int waits);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    @(posedge clk);
    while (pready !== 1'b1) begin
      waits++;
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [rta_cfg_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_xfer(1'b1, addr, data, rdata, err, waits);
    check_value($sformatf("pslverr on write to 0x%h", addr), 32'(err), 32'h0);
    check_value($sformatf("pready wait states on write to 0x%h", addr), waits, 0);
  endtask

  task automatic apb_read(input logic [rta_cfg_pkg::ADDR_W-1:0] addr, output logic [31:0] data);
    logic err;
    int   waits;
    int   exp_waits;
    // One wait state for the result window and none for registers
    exp_waits = (addr >= rta_cfg_pkg::RES_BASE) ? 1 : 0;
    apb_xfer(1'b0, addr, 32'h0, data, err, waits);
    check_value($sformatf("pslverr on read of 0x%h", addr), 32'(err), 32'h0);
    check_value($sformatf("pready wait states on read of 0x%h", addr), waits, exp_waits);
  endtask

  task automatic apb_expect_err(input logic write, input logic [rta_cfg_pkg::ADDR_W-1:0] addr,
                                input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_xfer(write, addr, data, rdata, err, waits);
    check_value($sformatf("pslverr on access to 0x%h", addr), 32'(err), 32'h1);
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================
  function automatic longint edge_val(int ax, int ay, int bx, int by, int px, int py);
    return longint'(bx - ax) * longint'(py - ay) - longint'(by - ay) * longint'(px - ax);
  endfunction

  function automatic bit covers(int t, int px, int py);
    longint e0, e1, e2;
    e0 = edge_val(tri_x[t][0], tri_y[t][0], tri_x[t][1], tri_y[t][1], px, py);
    e1 = edge_val(tri_x[t][1], tri_y[t][1], tri_x[t][2], tri_y[t][2], px, py);
    e2 = edge_val(tri_x[t][2], tri_y[t][2], tri_x[t][0], tri_y[t][0], px, py);
    return (e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0);
  endfunction

  // Nearest covering triangle wins and the first one stays on equal depth
  function automatic logic [31:0] model_pixel(int px, int py);
    rta_geom_pkg::result_t res;
    int best;
    bit found;
    res   = '0;
    best  = 0;
    found = 1'b0;
    for (int t = 0; t < model_count; t++) begin
      if (covers(t, px, py) && (!found || tri_depth[t] < tri_depth[best])) begin
        found = 1'b1;
        best  = t;
      end
    end
    if (found) begin
      res.hit       = 1'b1;
      res.depth     = 16'(tri_depth[best]);
      res.shader_id = 8'(tri_sid[best]);
    end
    return res;
  endfunction

  function automatic int rand_range(int lo, int hi);
    int r;
    r = $random(seed) % (hi - lo + 1);
    if (r < 0)
      r = r + (hi - lo + 1);
    return lo + r;
  endfunction

  // ==========================================================================
  // Helpers
  // ==========================================================================
  task automatic load_triangle(input int idx, input int x0, y0, x1, y1, x2, y2,
                               input int depth, sid);
    rta_geom_pkg::tri_word_u word;
    logic [rta_cfg_pkg::ADDR_W-1:0] base;
    tri_x[idx][0]  = x0;
    tri_y[idx][0]  = y0;
    tri_x[idx][1]  = x1;
    tri_y[idx][1]  = y1;
    tri_x[idx][2]  = x2;
    tri_y[idx][2]  = y2;
    tri_depth[idx] = depth;
    tri_sid[idx]   = sid;
    base = rta_cfg_pkg::TRI_BASE + 12'(idx * rta_cfg_pkg::TRI_WORDS * 4);
    for (int v = 0; v < 3; v++) begin
      word.vtx.x = 16'(tri_x[idx][v]);
      word.vtx.y = 16'(tri_y[idx][v]);
      apb_write(base + 12'(v * 4), word);
    end
    word                = '0;
    word.attr.depth     = 16'(depth);
    word.attr.shader_id = 8'(sid);
    apb_write(base + 12'd12, word);
  endtask

  task automatic wait_done();
    while (irq !== 1'b1)
      @(posedge clk);
  endtask

  task automatic run_image(input int w, input int h);
    logic [31:0] data;
    apb_write(rta_cfg_pkg::REG_SIZE, {16'h0, 8'(h), 8'(w)});
    apb_write(rta_cfg_pkg::REG_TRI_COUNT, model_count);
    apb_write(rta_cfg_pkg::REG_CTRL, 32'h1);
    wait_done();
    apb_read(rta_cfg_pkg::REG_STATUS, data);
    check_value("STATUS after run", data, 32'h2);
  endtask

  task automatic compare_image(input int w, input int h, output int hits);
    logic [31:0] data;
    hits = 0;
    for (int y = 0; y < h; y++) begin
      for (int x = 0; x < w; x++) begin
        apb_read(rta_cfg_pkg::RES_BASE + 12'((y * w + x) * 4), data);
        check_value($sformatf("prdata result (%0d,%0d)", x, y), data, model_pixel(x, y));
        if (data[31])
          hits++;
      end
    end
  endtask

  // ==========================================================================
  // Tests
  // ==========================================================================
  task automatic reset_and_registers();
    logic [31:0] data;
    apb_read(rta_cfg_pkg::REG_STATUS, data);
    check_value("STATUS after reset", data, 32'h0);
    check_value("irq after reset", 32'(irq), 32'h0);
    apb_read(rta_cfg_pkg::REG_SIZE, data);
    check_value("SIZE after reset", data, 32'h0);
    apb_read(rta_cfg_pkg::REG_TRI_COUNT, data);
    check_value("TRI_COUNT after reset", data, 32'h0);
    apb_write(rta_cfg_pkg::REG_SIZE, 32'h0000_0A05);
    apb_read(rta_cfg_pkg::REG_SIZE, data);
    check_value("SIZE", data, 32'h0000_0A05);
    apb_write(rta_cfg_pkg::REG_TRI_COUNT, 32'd7);
    apb_read(rta_cfg_pkg::REG_TRI_COUNT, data);
    check_value("TRI_COUNT", data, 32'd7);
  endtask

  task automatic single_triangle_image();
    int hits;
    // Covers the pixels with x + y <= 3 including edges
    load_triangle(0, 0, 0, 3, 0, 0, 3, 16'h0040, 8'h05);
    model_count = 1;
    run_image(4, 4);
    compare_image(4, 4, hits);
    check_value("hit count", hits, 10);
  endtask

  task automatic overlap_and_depth();
    int hits;
    int ties;
    int covered_px;
    int depths [3];
    depths = '{300, 100, 100};
    // One vertex per corner region keeps the three triangles overlapping
    for (int t = 0; t < 3; t++) begin
      load_triangle(t, rand_range(-8, 3), rand_range(-8, 3),
                    rand_range(18, 28), rand_range(-8, 8),
                    rand_range(-4, 20), rand_range(18, 28),
                    depths[t], 8'h11 * (t + 1));
    end
    model_count = 3;
    run_image(16, 16);
    compare_image(16, 16, hits);
    ties       = 0;
    covered_px = 0;
    for (int y = 0; y < 16; y++) begin
      for (int x = 0; x < 16; x++) begin
        if (covers(0, x, y) || covers(1, x, y) || covers(2, x, y))
          covered_px++;
        if (covers(1, x, y) && covers(2, x, y))
          ties++;
      end
    end
    check_value("hit count", hits, covered_px);
    assert (ties > 0)
      else stop_fail("no pixel is covered by both equal-depth triangles");
  endtask

  task automatic zero_triangle_runs();
    logic [31:0] data;
    model_count = 0;
    run_image(8, 8);
    check_value("irq after run", 32'(irq), 32'h1);
    for (int p = 0; p < 64; p++) begin
      apb_read(rta_cfg_pkg::RES_BASE + 12'(p * 4), data);
      check_value($sformatf("prdata result %0d", p), data, 32'h0);
    end
    // Next start clears done and irq
    apb_write(rta_cfg_pkg::REG_CTRL, 32'h1);
    apb_read(rta_cfg_pkg::REG_STATUS, data);
    check_value("STATUS after restart", data, 32'h1);
    check_value("irq after restart", 32'(irq), 32'h0);
    wait_done();
  endtask

  task automatic error_responses();
    logic [31:0] data;
    int hits;
    apb_write(rta_cfg_pkg::REG_SIZE, 32'h0000_0404);
    apb_expect_err(1'b0, rta_cfg_pkg::RES_BASE + 12'(16 * 4), 32'h0);
    apb_expect_err(1'b1, 12'h010, 32'h1234_5678);
    apb_expect_err(1'b0, rta_cfg_pkg::TRI_BASE, 32'h0);
    // Long run with the three triangles still loaded
    model_count = 3;
    apb_write(rta_cfg_pkg::REG_SIZE, 32'h0000_1010);
    apb_write(rta_cfg_pkg::REG_TRI_COUNT, 32'd3);
    apb_write(rta_cfg_pkg::REG_CTRL, 32'h1);
    apb_expect_err(1'b1, rta_cfg_pkg::REG_SIZE, 32'h0000_0202);
    apb_read(rta_cfg_pkg::REG_SIZE, data);
    check_value("SIZE after refused write", data, 32'h0000_1010);
    wait_done();
    // Opposite winding this time
    load_triangle(0, 3, 3, 0, 3, 3, 0, 16'h0007, 8'h9A);
    model_count = 1;
    run_image(4, 4);
    compare_image(4, 4, hits);
    check_value("hit count", hits, 10);
  endtask

  initial begin
    seed    = 20;
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    model_count = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    reset_and_registers();
    single_triangle_image();
    overlap_and_depth();
    zero_triangle_runs();
    error_responses();

    if (rta_top_inst.handshake_chk.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "handshake assertions failed");
    end
  end

endmodule

`default_nettype wire

/* dv/rta_chk.sv */
// Ray and APB handshake checks
`default_nettype none

module rta_chk (
  input logic                           clk,
  input logic                           rst,
  input logic                           pready,
  input logic                           pslverr,
  input logic                           ray_valid,
  input logic                           ray_ready,
  input logic [7:0]                     ray_x,
  input logic [7:0]                     ray_y,
  input logic [rta_cfg_pkg::PIX_AW-1:0] ray_pix
);

  int fail_count = 0;

  // Error response only in the completing cycle
  slverr_with_ready: assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
    else begin
      $error("pslverr high without pready");
      fail_count++;
    end

  // Valid holds until the core takes the ray
  valid_holds: assert property (@(posedge clk) disable iff (rst)
                                ray_valid && !ray_ready |=> ray_valid)
    else begin
      $error("ray_valid dropped before ray_ready");
      fail_count++;
    end

  // Ray data frozen while stalled
  data_stable: assert property (@(posedge clk) disable iff (rst)
                                ray_valid && !ray_ready |=> $stable({ray_x, ray_y, ray_pix}))
    else begin
      $error("ray data changed while stalled");
      fail_count++;
    end

endmodule

bind rta_top rta_chk handshake_chk (
  .clk(clk),
  .rst(rst),
  .pready(pready),
  .pslverr(pslverr),
  .ray_valid(ray_valid),
  .ray_ready(ray_ready),
  .ray_x(ray_x),
  .ray_y(ray_y),
  .ray_pix(ray_pix)
);

`default_nettype wire

/* logic/rta_top.sv */
// Ray-casting accelerator top level
`default_nettype none

module rta_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [rta_cfg_pkg::ADDR_W-1:0]    paddr,
  input  logic [31:0]                       pwdata,
  output logic [31:0]                       prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic                              irq
);

  // ==========================================================================
  // Register block outputs
  // ==========================================================================
  logic start, run_done;
  logic [7:0] width, height;
  logic [rta_cfg_pkg::TRI_CNT_W-1:0] tri_count;
  logic tri_we;
  logic [rta_cfg_pkg::TRI_AW-1:0] tri_waddr;
  logic [31:0] tri_wdata;
  logic res_re;
  logic [rta_cfg_pkg::PIX_AW-1:0] res_raddr;
  rta_geom_pkg::result_t res_rdata;

  // Ray handshake
  logic ray_valid, ray_ready;
  logic [7:0] ray_x, ray_y;
  logic [rta_cfg_pkg::PIX_AW-1:0] ray_pix;

  // Core memory ports
  logic tri_re;
  logic [rta_cfg_pkg::TRI_AW-1:0] tri_raddr;
  rta_geom_pkg::tri_word_u tri_rdata;
  logic res_we;
  logic [rta_cfg_pkg::PIX_AW-1:0] res_waddr;
  rta_geom_pkg::result_t res_wdata;

  apb_regs regs
   (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .run_done(run_done),
    .start(start),
    .busy(),
    .irq(irq),
    .width(width),
    .height(height),
    .tri_count(tri_count),
    .tri_we(tri_we),
    .tri_waddr(tri_waddr),
    .tri_wdata(tri_wdata),
    .res_re(res_re),
    .res_raddr(res_raddr),
    .res_rdata(res_rdata)
    );

  command_processor cmd_proc
   (
    .clk(clk),
    .rst(rst),
    .start(start),
    .width(width),
    .height(height),
    .ray_valid(ray_valid),
    .ray_x(ray_x),
    .ray_y(ray_y),
    .ray_pix(ray_pix),
    .ray_ready(ray_ready),
    .res_we(res_we),
    .run_done(run_done)
    );

  mem_triangle memory_triangle
   (
    .clk(clk),
    .tri_we(tri_we),
    .tri_waddr(tri_waddr),
    .tri_wdata(tri_wdata),
    .tri_re(tri_re),
    .tri_raddr(tri_raddr),
    .tri_rdata(tri_rdata)
    );

  ic_core ic
   (
    .clk(clk),
    .rst(rst),
    .ray_valid(ray_valid),
    .ray_x(ray_x),
    .ray_y(ray_y),
    .ray_pix(ray_pix),
    .ray_ready(ray_ready),
    .tri_count(tri_count),
    .tri_re(tri_re),
    .tri_raddr(tri_raddr),
    .tri_rdata(tri_rdata),
    .res_we(res_we),
    .res_waddr(res_waddr),
    .res_wdata(res_wdata)
    );

  mem_result memory_result
   (
    .clk(clk),
    .res_we(res_we),
    .res_waddr(res_waddr),
    .res_wdata(res_wdata),
    .res_re(res_re),
    .res_raddr(res_raddr),
    .res_rdata(res_rdata)
    );

endmodule

`default_nettype wire

/* logic/mem_result.sv */
// Result memory
`default_nettype none

module mem_result (
  input  logic                              clk,
  input  logic                              res_we,
  input  logic [rta_cfg_pkg::PIX_AW-1:0]    res_waddr,
  input  rta_geom_pkg::result_t             res_wdata,
  input  logic                              res_re,
  input  logic [rta_cfg_pkg::PIX_AW-1:0]    res_raddr,
  output rta_geom_pkg::result_t             res_rdata
);

  // One word per pixel
  rta_geom_pkg::result_t mem [rta_cfg_pkg::MAX_PIXELS];

  always_ff @(posedge clk) begin
    if (res_we)
      mem[res_waddr] <= res_wdata;
    // Registered read for the APB side
    if (res_re)
      res_rdata <= mem[res_raddr];
  end

endmodule

`default_nettype wire

/* logic/ic_core.sv */
// Ray and triangle intersection core
`default_nettype none

module ic_core (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 ray_valid,
  input  logic [7:0]                           ray_x,
  input  logic [7:0]                           ray_y,
  input  logic [rta_cfg_pkg::PIX_AW-1:0]       ray_pix,
  output logic                                 ray_ready,
  input  logic [rta_cfg_pkg::TRI_CNT_W-1:0]    tri_count,
  output logic                                 tri_re,
  output logic [rta_cfg_pkg::TRI_AW-1:0]       tri_raddr,
  input  rta_geom_pkg::tri_word_u              tri_rdata,
  output logic                                 res_we,
  output logic [rta_cfg_pkg::PIX_AW-1:0]       res_waddr,
  output rta_geom_pkg::result_t                res_wdata
);

  logic reading, drain, accept, last_rd, rd_valid, covered, take;
  logic [1:0] rd_word;
  logic [rta_cfg_pkg::TRI_AW-1:0] rd_addr, last_addr;
  logic [7:0] rx, ry;
  logic [rta_cfg_pkg::PIX_AW-1:0] rpix;
  logic signed [16:0] qx, qy;
  logic signed [35:0] e0, e1, e2;
  rta_geom_pkg::vertex_t v0, v1, v2;
  logic best_hit;
  logic [15:0] best_depth;
  logic [7:0] best_sid;

  // Signed area of the pixel against edge a to b
  function automatic logic signed [35:0] edge_fn(
    input rta_geom_pkg::vertex_t a,
    input rta_geom_pkg::vertex_t b,
    input logic signed [16:0]    x,
    input logic signed [16:0]    y
  );
    logic signed [17:0] dx, dy, ex, ey;
    dx = $signed(b.x) - $signed(a.x);
    dy = $signed(b.y) - $signed(a.y);
    ex = x - $signed(a.x);
    ey = y - $signed(a.y);
    return dx * ey - dy * ex;
  endfunction

  // ==========================================================================
  // Control
  // ==========================================================================
  assign accept    = ray_valid & ray_ready;
  assign last_addr = {tri_count[rta_cfg_pkg::TRI_CNT_W-2:0], 2'b00} - 1'b1;
  assign last_rd   = reading & (rd_addr == last_addr);
  assign tri_re    = reading;
  assign tri_raddr = rd_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      ray_ready <= 1'b0;
      reading   <= 1'b0;
      drain     <= 1'b0;
      res_we    <= 1'b0;
      rd_valid  <= 1'b0;
    end else begin
      rd_valid <= reading;
      if (accept) begin
        ray_ready <= 1'b0;
        if (tri_count != '0)
          reading <= 1'b1;
        else
          drain <= 1'b1;
      end else if (last_rd) begin
        reading <= 1'b0;
        drain   <= 1'b1;
      end else if (drain) begin
        drain  <= 1'b0;
        res_we <= 1'b1;
      end else if (res_we) begin
        res_we    <= 1'b0;
        ray_ready <= 1'b1;
      end else if (!ray_ready && !reading) begin
        ray_ready <= 1'b1;
      end
    end
  end

  // ==========================================================================
  // Edge tests and nearest hit
  // ==========================================================================
  assign qx = $signed({9'b0, rx});
  assign qy = $signed({9'b0, ry});
  assign e0 = edge_fn(v0, v1, qx, qy);
  assign e1 = edge_fn(v1, v2, qx, qy);
  assign e2 = edge_fn(v2, v0, qx, qy);

  // Either winding counts, edges included
  assign covered = ((e0 >= 0) && (e1 >= 0) && (e2 >= 0)) ||
                   ((e0 <= 0) && (e1 <= 0) && (e2 <= 0));

  // Strict compare keeps the lower index on a tie
  assign take = rd_valid && (rd_word == 2'd3) && covered &&
                (!best_hit || (tri_rdata.attr.depth < best_depth));

  always_ff @(posedge clk) begin
    rd_word <= rd_addr[1:0];
    if (accept) begin
      rx         <= ray_x;
      ry         <= ray_y;
      rpix       <= ray_pix;
      rd_addr    <= '0;
      best_hit   <= 1'b0;
      best_depth <= '0;
      best_sid   <= '0;
    end else begin
      if (reading)
        rd_addr <= rd_addr + 1'b1;
      if (take) begin
        best_hit   <= 1'b1;
        best_depth <= tri_rdata.attr.depth;
        best_sid   <= tri_rdata.attr.shader_id;
      end
    end
    if (rd_valid) begin
      case (rd_word)
        2'd0:    v0 <= tri_rdata.vtx;
        2'd1:    v1 <= tri_rdata.vtx;
        2'd2:    v2 <= tri_rdata.vtx;
        default: ;
      endcase
    end
  end

  assign res_waddr = rpix;
  assign res_wdata = '{hit: best_hit, unused: 7'b0, depth: best_depth, shader_id: best_sid};

endmodule

`default_nettype wire

/* logic/mem_triangle.sv */
// Triangle memory
`default_nettype none

module mem_triangle (
  input  logic                              clk,
  input  logic                              tri_we,
  input  logic [rta_cfg_pkg::TRI_AW-1:0]    tri_waddr,
  input  logic [31:0]                       tri_wdata,
  input  logic                              tri_re,
  input  logic [rta_cfg_pkg::TRI_AW-1:0]    tri_raddr,
  output rta_geom_pkg::tri_word_u           tri_rdata
);

  // Four consecutive words per triangle
  rta_geom_pkg::tri_word_u mem [rta_cfg_pkg::NUM_TRI * rta_cfg_pkg::TRI_WORDS];

  // Host write port
  always_ff @(posedge clk) begin
    if (tri_we)
      mem[tri_waddr] <= tri_wdata;
  end

  // Core read port, data one cycle after the enable
  always_ff @(posedge clk) begin
    if (tri_re)
      tri_rdata <= mem[tri_raddr];
  end

endmodule

`default_nettype wire

/* logic/command_processor.sv */
// Pixel sequencer
`default_nettype none

module command_processor (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              start,
  input  logic [7:0]                        width,
  input  logic [7:0]                        height,
  output logic                              ray_valid,
  output logic [7:0]                        ray_x,
  output logic [7:0]                        ray_y,
  output logic [rta_cfg_pkg::PIX_AW-1:0]    ray_pix,
  input  logic                              ray_ready,
  input  logic                              res_we,
  output logic                              run_done
);

  logic [7:0] px, py;
  logic [rta_cfg_pkg::PIX_AW-1:0] pix;
  logic [15:0] total, wr_cnt;
  logic running, zero_pend, last_wr;

  assign total   = width * height;
  assign last_wr = running & res_we & (wr_cnt == total - 16'd1);

  // Empty image finishes the cycle after start
  assign run_done = last_wr | zero_pend;

  assign ray_x   = px;
  assign ray_y   = py;
  assign ray_pix = pix;

  always_ff @(posedge clk) begin
    if (rst) begin
      ray_valid <= 1'b0;
      running   <= 1'b0;
      zero_pend <= 1'b0;
      px        <= '0;
      py        <= '0;
      pix       <= '0;
      wr_cnt    <= '0;
    end else begin
      zero_pend <= start & (total == 16'd0);
      if (start && (total != 16'd0)) begin
        ray_valid <= 1'b1;
        running   <= 1'b1;
        px        <= '0;
        py        <= '0;
        pix       <= '0;
        wr_cnt    <= '0;
      end else begin
        // Raster order, x fastest
        if (ray_valid && ray_ready) begin
          pix <= pix + 1'b1;
          if (px == width - 8'd1) begin
            px <= '0;
            if (py == height - 8'd1)
              ray_valid <= 1'b0;
            else
              py <= py + 8'd1;
          end else begin
            px <= px + 8'd1;
          end
        end
        // Count results coming back from the core
        if (running && res_we) begin
          wr_cnt <= wr_cnt + 16'd1;
          if (last_wr)
            running <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/apb_regs.sv */
// APB register block
`default_nettype none

module apb_regs (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [rta_cfg_pkg::ADDR_W-1:0]       paddr,
  input  logic [31:0]                          pwdata,
  output logic [31:0]                          prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  input  logic                                 run_done,
  output logic                                 start,
  output logic                                 busy,
  output logic                                 irq,
  output logic [7:0]                           width,
  output logic [7:0]                           height,
  output logic [rta_cfg_pkg::TRI_CNT_W-1:0]    tri_count,
  output logic                                 tri_we,
  output logic [rta_cfg_pkg::TRI_AW-1:0]       tri_waddr,
  output logic [31:0]                          tri_wdata,
  output logic                                 res_re,
  output logic [rta_cfg_pkg::PIX_AW-1:0]       res_raddr,
  input  rta_geom_pkg::result_t                res_rdata
);

  logic access, mapped, err, wr_ok, done;
  logic is_ctrl, is_status, is_size, is_tcnt, is_tri, is_res;
  logic res_rd, res_wait, in_range;
  logic [15:0] pix_total, size_px;

  // ==========================================================================
  // Address decode
  // ==========================================================================
  assign access    = psel & penable;
  assign is_ctrl   = (paddr == rta_cfg_pkg::REG_CTRL);
  assign is_status = (paddr == rta_cfg_pkg::REG_STATUS);
  assign is_size   = (paddr == rta_cfg_pkg::REG_SIZE);
  assign is_tcnt   = (paddr == rta_cfg_pkg::REG_TRI_COUNT);
  assign is_tri    = (paddr[11:10] == rta_cfg_pkg::TRI_BASE[11:10]);
  assign is_res    = (paddr[11] == rta_cfg_pkg::RES_BASE[11]);
  assign mapped    = is_ctrl | is_status | is_size | is_tcnt |
                     ((is_tri | is_res) & (paddr[1:0] == 2'b00));

  assign pix_total = width * height;
  assign size_px   = pwdata[7:0] * pwdata[15:8];
  assign in_range  = (16'(paddr[rta_cfg_pkg::PIX_AW+1:2]) < pix_total);

  always_comb begin
    err = 1'b0;
    if (!mapped)
      err = 1'b1;
    else if (is_tri)
      err = !pwrite || busy;
    else if (is_res)
      err = pwrite || !in_range;
    else if (pwrite && (is_size || is_tcnt) && busy)
      err = 1'b1;
    else if (pwrite && is_size && (size_px > 16'(rta_cfg_pkg::MAX_PIXELS)))
      err = 1'b1;
    else if (pwrite && is_tcnt && (pwdata > 32'(rta_cfg_pkg::NUM_TRI)))
      err = 1'b1;
  end

  // Result reads wait one cycle for the RAM
  assign res_rd  = access & is_res & ~pwrite & mapped;
  assign pready  = access & (~res_rd | res_wait);
  assign pslverr = pready & err;
  assign wr_ok   = pready & pwrite & ~err;

  assign start = wr_ok & is_ctrl & pwdata[0] & ~busy;
  assign irq   = done;

  // Memory side ports
  assign tri_we    = wr_ok & is_tri;
  assign tri_waddr = paddr[rta_cfg_pkg::TRI_AW+1:2];
  assign tri_wdata = pwdata;
  assign res_re    = res_rd & ~res_wait;
  assign res_raddr = paddr[rta_cfg_pkg::PIX_AW+1:2];

  always_comb begin
    prdata = '0;
    if (is_status)
      prdata = {30'b0, done, busy};
    else if (is_size)
      prdata = {16'b0, height, width};
    else if (is_tcnt)
      prdata = 32'(tri_count);
    else if (is_res && res_wait)
      prdata = res_rdata;
  end

  // ==========================================================================
  // Registers and run flags
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      res_wait  <= 1'b0;
      width     <= '0;
      height    <= '0;
      tri_count <= '0;
    end else begin
      res_wait <= res_rd & ~res_wait;
      if (run_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end else if (start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end
      if (wr_ok && is_size) begin
        width  <= pwdata[7:0];
        height <= pwdata[15:8];
      end
      if (wr_ok && is_tcnt)
        tri_count <= pwdata[rta_cfg_pkg::TRI_CNT_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* logic/rta_geom_pkg.sv */
// Triangle and result word types
`default_nettype none

package rta_geom_pkg;

  // One vertex in screen space, x in the upper half
  typedef struct packed {
    logic signed [15:0] x;
    logic signed [15:0] y;
  } vertex_t;

  // Fourth word of a triangle
  typedef struct packed {
    logic [15:0] depth;
    logic [7:0]  shader_id;
    logic [7:0]  unused;
  } tri_attr_t;

  // Slots 0 to 2 hold vertices, slot 3 holds the attributes
  typedef union packed {
    vertex_t   vtx;
    tri_attr_t attr;
  } tri_word_u;

  // Per-pixel result, all zeros on a miss
  typedef struct packed {
    logic        hit;
    logic [6:0]  unused;
    logic [15:0] depth;
    logic [7:0]  shader_id;
  } result_t;

endpackage

`default_nettype wire

/* logic/rta_cfg_pkg.sv */
// Accelerator register map and sizes
`default_nettype none

package rta_cfg_pkg;

  // ==========================================================================
  // APB address space
  // ==========================================================================
  localparam int ADDR_W = 12;

  // Control and status registers
  localparam logic [ADDR_W-1:0] REG_CTRL      = 12'h000;
  localparam logic [ADDR_W-1:0] REG_STATUS    = 12'h004;
  localparam logic [ADDR_W-1:0] REG_SIZE      = 12'h008;
  localparam logic [ADDR_W-1:0] REG_TRI_COUNT = 12'h00C;

  // Memory windows
  localparam logic [ADDR_W-1:0] TRI_BASE = 12'h400;
  localparam logic [ADDR_W-1:0] RES_BASE = 12'h800;

  // ==========================================================================
  // Capacities
  // ==========================================================================
  localparam int NUM_TRI    = 64;
  localparam int TRI_WORDS  = 4;
  localparam int MAX_PIXELS = 512;

  // Internal address and count widths
  localparam int TRI_AW    = 8;
  localparam int PIX_AW    = 9;
  localparam int TRI_CNT_W = $clog2(NUM_TRI + 1);

endpackage

`default_nettype wire
